/* bus_pkg.sv */
package bus_pkg;

  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int axi_data_w = 64;

  typedef logic [addr_w-1:0]       addr_t;
  typedef logic [data_w-1:0]       word_t;
  typedef logic [axi_data_w-1:0]   axi_data_t;
  typedef logic [data_w/8-1:0]     strb4_t;
  typedef logic [axi_data_w/8-1:0] strb8_t;
  typedef logic [2:0]              size_t;
  typedef logic [1:0]              burst_t;
  typedef logic [7:0]              len_t;
  typedef logic [3:0]              id_t;
  typedef logic [1:0]              resp_t;

  // axsize encodings
  localparam size_t size_byte = 3'b000;
  localparam size_t size_half = 3'b001;
  localparam size_t size_word = 3'b010;

  localparam burst_t burst_incr = 2'b01;
  localparam len_t   len_single = 8'd0;  // one beat

  // one id per requester
  localparam id_t id_fetch = 4'd0;
  localparam id_t id_lsu   = 4'd1;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    id_t    id;
  } axi_ar_t;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    id_t    id;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;
    strb8_t    strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    resp_t     resp;
    logic      last;
    id_t       id;
  } axi_r_t;

  typedef struct packed {
    resp_t resp;
    id_t   id;
  } axi_b_t;

  typedef struct packed {
    addr_t  addr;
    strb4_t strb;
  } lsu_rd_req_t;

  typedef struct packed {
    addr_t  addr;
    word_t  data;
    strb4_t strb;  // unshifted, lsb aligned
  } lsu_wr_req_t;

endpackage

/* soc_map_pkg.sv */
package soc_map_pkg;
  import bus_pkg::*;

  // clint device region
  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t clint_size = 32'h0001_0000;

  // mtime words inside clint
  localparam addr_t rtc_addr_lo = clint_base + 32'h0000_bff8;
  localparam addr_t rtc_addr_hi = rtc_addr_lo + 32'd4;

  typedef logic [63:0] mtime_t;

  function automatic logic in_clint(input addr_t addr);
    return (addr >= clint_base) && (addr < clint_base + clint_size);
  endfunction

  // word decode within the region
  function automatic logic is_rtc(input addr_t addr);
    return in_clint(addr) &&
           ((addr[15:2] == rtc_addr_lo[15:2]) || (addr[15:2] == rtc_addr_hi[15:2]));
  endfunction

endpackage

/* clint_timer.sv */
`timescale 1ns/1ps

module clint_timer import bus_pkg::*, soc_map_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req_i,
  input  addr_t addr_i,
  output word_t rdata_o,
  output logic  rvalid_o
);

  mtime_t mtime;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end else begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= req_i;  // answer next cycle
    end
  end

  // value captured at request time
  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= (addr_i == rtc_addr_hi) ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

/* lane_align.sv */
`timescale 1ns/1ps

module lane_align import bus_pkg::*; (
  input  lsu_wr_req_t lsu_wr_req_i,
  input  strb4_t      lsu_rd_strb_i,
  input  addr_t       rd_addr_i,
  input  axi_data_t   r_data_i,
  input  logic        rd_is_fetch_i,
  input  logic        rd_is_rtc_i,
  input  word_t       rtc_rdata_i,
  output axi_w_t      w_o,
  output size_t       size_rd_o,
  output size_t       size_wr_o,
  output word_t       rdata_o
);

  // strobe pattern to axsize
  function automatic size_t strb_to_size(input strb4_t strb);
    case (strb)
      4'b0001: return size_byte;
      4'b0011: return size_half;
      default: return size_word;
    endcase
  endfunction

  logic [1:0] wr_off;
  word_t      wr_word;
  strb4_t     wr_strb;
  word_t      r_half;

  assign wr_off  = lsu_wr_req_i.addr[1:0];
  assign wr_word = lsu_wr_req_i.data << {wr_off, 3'b000};
  assign wr_strb = lsu_wr_req_i.strb << wr_off;

  // data goes to both halves and the strobe picks one
  assign w_o.data = {wr_word, wr_word};
  assign w_o.strb = lsu_wr_req_i.addr[2] ? {wr_strb, 4'b0000} : {4'b0000, wr_strb};
  assign w_o.last = 1'b1;  // single beat

  assign size_wr_o = strb_to_size(lsu_wr_req_i.strb);
  assign size_rd_o = strb_to_size(lsu_rd_strb_i);

  assign r_half = rd_addr_i[2] ? r_data_i[axi_data_w-1:data_w] : r_data_i[data_w-1:0];

  // pending timer load must not steal a fetch response
  assign rdata_o = (rd_is_rtc_i && !rd_is_fetch_i) ? rtc_rdata_i : r_half;

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*, soc_map_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // fetch
  input  logic        ifu_req_i,
  input  addr_t       ifu_addr_i,
  output logic        ifu_rvalid_o,

  // load / store
  input  logic        lsu_rd_i,
  input  lsu_rd_req_t lsu_rd_req_i,
  input  logic        lsu_wr_i,
  input  lsu_wr_req_t lsu_wr_req_i,
  output logic        lsu_rvalid_o,
  output logic        lsu_wready_o,

  // timer
  output logic        rtc_req_o,
  output logic        rdata_sel_rtc_o,
  input  logic        rtc_rvalid_i,

  // axi master
  output axi_ar_t     ar_o,
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  output axi_aw_t     aw_o,
  output logic        aw_valid_o,
  input  logic        aw_ready_i,
  output logic        w_valid_o,
  input  logic        w_ready_i,
  input  logic        r_valid_i,
  input  logic        b_valid_i,

  // from the aligner
  input  size_t       size_rd_i,
  input  size_t       size_wr_i
);

  typedef enum logic [2:0] {
    idle,
    if_addr,
    if_data,
    ls_addr,
    ls_read,
    ls_write_done
  } state_t;

  state_t state_q;
  state_t state_d;

  logic aw_done_q;
  logic w_done_q;
  logic aw_hs;
  logic w_hs;
  logic aw_done_now;
  logic w_done_now;
  logic rd_fetch;
  logic rd_done;
  logic ls_pending;

  assign ls_pending = lsu_rd_i | lsu_wr_i;
  assign rd_fetch   = (state_q == if_addr) || (state_q == if_data);

  assign rdata_sel_rtc_o = lsu_rd_i & is_rtc(lsu_rd_req_i.addr);
  assign rd_done         = rdata_sel_rtc_o ? rtc_rvalid_i : r_valid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (ifu_req_i) begin  // fetch wins from idle
          state_d = if_addr;
        end else if (ls_pending) begin
          state_d = ls_addr;
        end
      end
      if_addr: begin
        if (ar_ready_i) begin
          state_d = if_data;
        end
      end
      if_data: begin
        if (r_valid_i) begin
          state_d = ls_pending ? ls_addr : idle;  // lsu goes next
        end
      end
      ls_addr: begin
        if (lsu_wr_i) begin
          if (aw_done_now && w_done_now) begin
            state_d = ls_write_done;
          end
        end else if (rdata_sel_rtc_o || ar_ready_i) begin
          state_d = ls_read;
        end
      end
      ls_read: begin
        if (rd_done) begin
          state_d = ifu_req_i ? if_addr : idle;
        end
      end
      ls_write_done: begin
        if (b_valid_i) begin
          state_d = ifu_req_i ? if_addr : idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  // aw and w may complete in either order
  assign aw_hs       = aw_valid_o & aw_ready_i;
  assign w_hs        = w_valid_o & w_ready_i;
  assign aw_done_now = aw_done_q | aw_hs;
  assign w_done_now  = w_done_q | w_hs;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else if (state_q != ls_addr) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      if (aw_hs) aw_done_q <= 1'b1;
      if (w_hs) w_done_q <= 1'b1;
    end
  end

  assign ar_valid_o = (state_q == if_addr) ||
                      ((state_q == ls_addr) && !lsu_wr_i && lsu_rd_i && !rdata_sel_rtc_o);
  assign aw_valid_o = (state_q == ls_addr) && lsu_wr_i && !aw_done_q;
  assign w_valid_o  = (state_q == ls_addr) && lsu_wr_i && !w_done_q;

  // timer load bypasses axi
  assign rtc_req_o = (state_q == ls_addr) && !lsu_wr_i && rdata_sel_rtc_o;

  assign ifu_rvalid_o = (state_q == if_data) && r_valid_i;
  assign lsu_rvalid_o = (state_q == ls_read) && rd_done;
  assign lsu_wready_o = (state_q == ls_write_done) && b_valid_i;

  // address stays on the lsu side outside fetch states
  assign ar_o.addr  = rd_fetch ? ifu_addr_i : lsu_rd_req_i.addr;
  assign ar_o.len   = len_single;
  assign ar_o.size  = rd_fetch ? size_word : size_rd_i;
  assign ar_o.burst = burst_incr;
  assign ar_o.id    = rd_fetch ? id_fetch : id_lsu;

  assign aw_o.addr  = lsu_wr_req_i.addr;
  assign aw_o.len   = len_single;
  assign aw_o.size  = size_wr_i;
  assign aw_o.burst = burst_incr;
  assign aw_o.id    = id_lsu;

endmodule

/* cpu_bus_top.sv */
`timescale 1ns/1ps

module cpu_bus_top import bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  input  logic        ifu_req_i,
  input  addr_t       ifu_addr_i,
  output logic        ifu_rvalid_o,

  input  logic        lsu_rd_i,
  input  lsu_rd_req_t lsu_rd_req_i,
  output logic        lsu_rvalid_o,
  input  logic        lsu_wr_i,
  input  lsu_wr_req_t lsu_wr_req_i,
  output logic        lsu_wready_o,

  output word_t       rdata_o,  // both read responses

  output axi_ar_t     ar_o,
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  output axi_aw_t     aw_o,
  output logic        aw_valid_o,
  input  logic        aw_ready_i,
  output axi_w_t      w_o,
  output logic        w_valid_o,
  input  logic        w_ready_i,
  input  axi_r_t      r_i,
  input  logic        r_valid_i,
  output logic        r_ready_o,
  input  axi_b_t      b_i,
  input  logic        b_valid_i,
  output logic        b_ready_o
);

  logic  rtc_req;
  logic  rtc_sel;
  logic  rtc_rvalid;
  word_t rtc_rdata;
  size_t size_rd;
  size_t size_wr;

  assign r_ready_o = 1'b1;
  assign b_ready_o = 1'b1;

  bus_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req_i),
    .ifu_addr_i      (ifu_addr_i),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_rd_i        (lsu_rd_i),
    .lsu_rd_req_i    (lsu_rd_req_i),
    .lsu_wr_i        (lsu_wr_i),
    .lsu_wr_req_i    (lsu_wr_req_i),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_wready_o    (lsu_wready_o),
    .rtc_req_o       (rtc_req),
    .rdata_sel_rtc_o (rtc_sel),
    .rtc_rvalid_i    (rtc_rvalid),
    .ar_o            (ar_o),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .aw_o            (aw_o),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .w_valid_o       (w_valid_o),
    .w_ready_i       (w_ready_i),
    .r_valid_i       (r_valid_i),
    .b_valid_i       (b_valid_i && (b_i.id == id_lsu)),  // only the lsu writes
    .size_rd_i       (size_rd),
    .size_wr_i       (size_wr)
  );

  // ar address follows the granted reader through the data phase
  lane_align u_align (
    .lsu_wr_req_i  (lsu_wr_req_i),
    .lsu_rd_strb_i (lsu_rd_req_i.strb),
    .rd_addr_i     (ar_o.addr),
    .r_data_i      (r_i.data),
    .rd_is_fetch_i (ifu_rvalid_o),
    .rd_is_rtc_i   (rtc_sel),
    .rtc_rdata_i   (rtc_rdata),
    .w_o           (w_o),
    .size_rd_o     (size_rd),
    .size_wr_o     (size_wr),
    .rdata_o       (rdata_o)
  );

  clint_timer u_clint (
    .clk      (clk),
    .rst      (rst),
    .req_i    (rtc_req),
    .addr_i   (lsu_rd_req_i.addr),
    .rdata_o  (rtc_rdata),
    .rvalid_o (rtc_rvalid)
  );

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem import bus_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    bp_en_i,  // random ready/valid delays
  input  axi_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  axi_aw_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i
);

  axi_data_t   mem [0:255];  // indexed by addr[10:3]
  logic [31:0] seed;
  logic [1:0]  ar_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  r_wait;
  logic [1:0]  b_wait;
  logic        rd_pend;
  logic        aw_got;
  logic        w_got;
  addr_t       rd_addr;
  id_t         rd_id;
  addr_t       wr_addr;
  id_t         wr_id;
  axi_w_t      wr_beat;

  initial begin
    // bus idle from time zero
    ar_ready_o <= 1'b0;
    aw_ready_o <= 1'b0;
    w_ready_o  <= 1'b0;
    r_valid_o  <= 1'b0;
    b_valid_o  <= 1'b0;
    r_o        <= '0;
    b_o        <= '0;
    // each word holds its own scrambled address
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'h8000_0004 + 32'(i) * 32'd8, 32'h8000_0000 + 32'(i) * 32'd8} ^
               {2{32'h5a3c_96e1}};
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic pick_delay(output logic [1:0] d);
    seed = lcg_next(seed);
    d = bp_en_i ? seed[17:16] : 2'd0;
  endtask

  function automatic axi_data_t apply_strb(input axi_data_t old, input axi_w_t beat);
    axi_data_t res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (beat.strb[i]) res[8*i +: 8] = beat.data[8*i +: 8];
    end
    return res;
  endfunction

  always @(posedge clk) begin : slave
    logic [1:0] d;
    if (rst) begin
      seed = 32'd13;
      ar_ready_o <= 1'b0;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      r_valid_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      r_o        <= '0;
      b_o        <= '0;
      rd_pend    <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      ar_wait    <= 2'd0;
      aw_wait    <= 2'd0;
      w_wait     <= 2'd0;
      r_wait     <= 2'd0;
      b_wait     <= 2'd0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        rd_pend    <= 1'b1;
        rd_addr    <= ar_i.addr;
        rd_id      <= ar_i.id;
        pick_delay(d);
        r_wait <= d;
        pick_delay(d);
        ar_wait <= d;
      end else if (ar_valid_i && !rd_pend) begin
        if (ar_wait == 2'd0) ar_ready_o <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end

      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        rd_pend   <= 1'b0;
      end else if (rd_pend && !r_valid_o) begin
        if (r_wait == 2'd0) begin
          r_valid_o <= 1'b1;
          r_o.data  <= mem[rd_addr[10:3]];
          r_o.resp  <= 2'b00;
          r_o.last  <= 1'b1;
          r_o.id    <= rd_id;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end

      // aw and w are taken independently
      if (aw_valid_i && aw_ready_o) begin
        aw_ready_o <= 1'b0;
        aw_got     <= 1'b1;
        wr_addr    <= aw_i.addr;
        wr_id      <= aw_i.id;
        pick_delay(d);
        aw_wait <= d;
      end else if (aw_valid_i && !aw_got) begin
        if (aw_wait == 2'd0) aw_ready_o <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end

      if (w_valid_i && w_ready_o) begin
        w_ready_o <= 1'b0;
        w_got     <= 1'b1;
        wr_beat   <= w_i;
        pick_delay(d);
        w_wait <= d;
      end else if (w_valid_i && !w_got) begin
        if (w_wait == 2'd0) w_ready_o <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end

      if (aw_got && w_got && !b_valid_o) begin
        if (b_wait == 2'd0) begin
          mem[wr_addr[10:3]] <= apply_strb(mem[wr_addr[10:3]], wr_beat);
          b_valid_o <= 1'b1;
          b_o.resp  <= 2'b00;
          b_o.id    <= wr_id;
          aw_got    <= 1'b0;
          w_got     <= 1'b0;
          pick_delay(d);
          b_wait <= d;
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
      if (b_valid_o && b_ready_i) b_valid_o <= 1'b0;
    end
  end

endmodule

/* tb_cpu_bus.sv */
`timescale 1ns/1ps

module tb_cpu_bus import bus_pkg::*, soc_map_pkg::*; ();

  localparam int wait_limit = 200;  // cycles per response

  logic        clk;
  logic        rst;
  logic        bp_en;
  logic        ifu_req;
  addr_t       ifu_addr;
  logic        ifu_rvalid;
  logic        lsu_rd;
  lsu_rd_req_t lsu_rd_req;
  logic        lsu_rvalid;
  logic        lsu_wr;
  lsu_wr_req_t lsu_wr_req;
  logic        lsu_wready;
  word_t       rdata;
  axi_ar_t     ar;
  logic        ar_valid;
  logic        ar_ready;
  axi_aw_t     aw;
  logic        aw_valid;
  logic        aw_ready;
  axi_w_t      w;
  logic        w_valid;
  logic        w_ready;
  axi_r_t      r;
  logic        r_valid;
  logic        r_ready;
  axi_b_t      b;
  logic        b_valid;
  logic        b_ready;

  int          checks = 0;
  int          errors = 0;
  logic        aborted = 1'b0;
  logic [31:0] rng;
  size_t       last_ar_size;
  size_t       last_aw_size;
  logic        ar_seen;

  cpu_bus_top uut (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .ifu_addr_i (ifu_addr), .ifu_rvalid_o (ifu_rvalid),
    .lsu_rd_i (lsu_rd), .lsu_rd_req_i (lsu_rd_req), .lsu_rvalid_o (lsu_rvalid),
    .lsu_wr_i (lsu_wr), .lsu_wr_req_i (lsu_wr_req), .lsu_wready_o (lsu_wready),
    .rdata_o (rdata),
    .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
    .aw_o (aw), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
    .w_o (w), .w_valid_o (w_valid), .w_ready_i (w_ready),
    .r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready),
    .b_i (b), .b_valid_i (b_valid), .b_ready_o (b_ready)
  );

  tb_axi_mem u_mem (
    .clk (clk), .rst (rst), .bp_en_i (bp_en),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready),
    .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t model_word(input addr_t addr);
    axi_data_t line;
    line = u_mem.mem[addr[10:3]];
    return addr[2] ? line[63:32] : line[31:0];
  endfunction

  // old word with the strobed bytes of the shifted store replaced
  function automatic word_t merge_word(input word_t old, input word_t data,
                                       input strb4_t strb, input logic [1:0] off);
    word_t  moved;
    strb4_t lanes;
    word_t  res;
    moved = data << {off, 3'b000};
    lanes = strb << off;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) res[8*i +: 8] = moved[8*i +: 8];
    end
    return res;
  endfunction

  task automatic check_val(input string name, input word_t got, input word_t exp);
    if (!aborted) begin
      checks++;
      assert (got === exp) else begin
        errors++;
        $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
    end
  endtask

  task automatic watch_bus();
    if (ar_valid && ar_ready) last_ar_size = ar.size;
    if (aw_valid && aw_ready) last_aw_size = aw.size;
    if (ar_valid) ar_seen = 1'b1;
  endtask

  // response kind is 0 for fetch, 1 for load and 2 for store
  task automatic wait_resp(input int which, input string what, output word_t data);
    int   n;
    logic hit;
    n = 0;
    hit = 1'b0;
    data = '0;
    while (!hit && !aborted) begin
      @(negedge clk);
      watch_bus();
      hit = (which == 0) ? ifu_rvalid : (which == 1) ? lsu_rvalid : lsu_wready;
      n++;
      if (!hit && n >= wait_limit) begin
        $display("timeout: no %s response after %0d cycles", what, n);
        errors++;
        aborted = 1'b1;
      end
    end
    data = rdata;
  endtask

  task automatic do_fetch(input addr_t addr, output word_t data);
    ifu_req = 1'b1;
    ifu_addr = addr;
    wait_resp(0, "fetch", data);
    @(negedge clk);
    ifu_req = 1'b0;
  endtask

  task automatic do_load(input addr_t addr, input strb4_t strb, output word_t data);
    lsu_rd = 1'b1;
    lsu_rd_req.addr = addr;
    lsu_rd_req.strb = strb;
    wait_resp(1, "load", data);
    @(negedge clk);
    lsu_rd = 1'b0;
  endtask

  task automatic do_store(input addr_t addr, input word_t data, input strb4_t strb);
    word_t unused;
    lsu_wr = 1'b1;
    lsu_wr_req.addr = addr;
    lsu_wr_req.data = data;
    lsu_wr_req.strb = strb;
    wait_resp(2, "store", unused);
    @(negedge clk);
    lsu_wr = 1'b0;
  endtask

  task automatic test_reset_outputs();
    check_val("ar_valid_o", 32'(ar_valid), 32'd0);
    check_val("aw_valid_o", 32'(aw_valid), 32'd0);
    check_val("w_valid_o", 32'(w_valid), 32'd0);
    check_val("ifu_rvalid_o", 32'(ifu_rvalid), 32'd0);
    check_val("lsu_rvalid_o", 32'(lsu_rvalid), 32'd0);
    check_val("lsu_wready_o", 32'(lsu_wready), 32'd0);
    check_val("r_ready_o", 32'(r_ready), 32'd1);  // tied high
    check_val("b_ready_o", 32'(b_ready), 32'd1);
  endtask

  task automatic test_fetch();
    addr_t a;
    word_t got;
    for (int i = 0; i < 6; i++) begin
      a = 32'h8000_0000 + 32'(i * 12);  // word offset 0 and 4 in turn
      last_ar_size = 3'b111;
      do_fetch(a, got);
      check_val("rdata_o", got, model_word(a));
      check_val("ar_o.size", 32'(last_ar_size), 32'(size_word));
    end
  endtask

  task automatic test_store();
    addr_t      a;
    word_t      old;
    word_t      data;
    word_t      got;
    strb4_t     strb;
    logic [1:0] off;
    size_t      sz;
    for (int k = 0; k < 7; k++) begin
      for (int h = 0; h < 2; h++) begin
        case (k)
          0, 1, 2, 3: begin
            strb = 4'b0001;
            off = 2'(k);
            sz = size_byte;
          end
          4, 5: begin
            strb = 4'b0011;
            off = 2'((k - 4) * 2);
            sz = size_half;
          end
          default: begin
            strb = 4'b1111;
            off = 2'd0;
            sz = size_word;
          end
        endcase
        a = 32'h8000_0100 + 32'(k * 16 + h * 4) + 32'(off);
        old = model_word(a);
        rng = lcg_next(rng);
        data = rng;
        last_aw_size = 3'b111;
        do_store(a, data, strb);
        check_val("aw_o.size", 32'(last_aw_size), 32'(sz));
        do_load({a[31:2], 2'b00}, 4'hf, got);
        check_val("rdata_o", got, merge_word(old, data, strb, off));
      end
    end
  endtask

  task automatic test_fetch_store();
    addr_t fa;
    addr_t sa;
    word_t exp_f;
    word_t got_f;
    word_t got_s;
    word_t sdata;
    int    n;
    int    f_at;
    int    s_at;
    fa = 32'h8000_0184;
    sa = 32'h8000_0200;
    exp_f = model_word(fa);
    rng = lcg_next(rng);
    sdata = rng;
    got_f = '0;
    n = 0;
    f_at = -1;
    s_at = -1;
    ifu_req = 1'b1;
    ifu_addr = fa;
    lsu_wr = 1'b1;
    lsu_wr_req.addr = sa;
    lsu_wr_req.data = sdata;
    lsu_wr_req.strb = 4'hf;
    while ((f_at < 0 || s_at < 0) && !aborted) begin
      @(negedge clk);
      n++;
      if (f_at < 0 && ifu_rvalid) begin
        f_at = n;
        got_f = rdata;
      end
      if (s_at < 0 && lsu_wready) s_at = n;
      if (f_at >= 0 && f_at < n) ifu_req = 1'b0;  // a cycle after its strobe
      if (s_at >= 0 && s_at < n) lsu_wr = 1'b0;
      if ((f_at < 0 || s_at < 0) && n >= wait_limit) begin
        $display("timeout: fetch and store not both done after %0d cycles", n);
        errors++;
        aborted = 1'b1;
      end
    end
    @(negedge clk);
    ifu_req = 1'b0;
    lsu_wr = 1'b0;
    if (!aborted) begin
      checks++;
      assert (f_at < s_at) else begin
        errors++;
        $display("store finished before the fetch that was requested with it");
      end
    end
    check_val("rdata_o", got_f, exp_f);
    do_load(sa, 4'hf, got_s);
    check_val("rdata_o", got_s, sdata);
  endtask

  task automatic test_timer();
    word_t lo1;
    word_t lo2;
    word_t hi;
    ar_seen = 1'b0;
    do_load(rtc_addr_lo, 4'hf, lo1);
    repeat (10) @(negedge clk);
    do_load(rtc_addr_lo, 4'hf, lo2);
    do_load(rtc_addr_hi, 4'hf, hi);
    if (!aborted) begin
      checks++;
      assert (lo2 - lo1 >= 32'd10) else begin
        errors++;
        $display("ERR rdata_o mtime step %h expected at least %h", lo2 - lo1, 32'd10);
      end
    end
    check_val("rdata_o", hi, 32'd0);  // mtime high word
    check_val("ar_valid_o", 32'(ar_seen), 32'd0);
  endtask

  initial begin
    rst = 1'b1;
    bp_en = 1'b0;
    ifu_req = 1'b0;
    ifu_addr = '0;
    lsu_rd = 1'b0;
    lsu_rd_req = '0;
    lsu_wr = 1'b0;
    lsu_wr_req = '0;
    rng = 32'd13;
    last_ar_size = 3'b111;
    last_aw_size = 3'b111;
    ar_seen = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_outputs();
    if (!aborted) test_fetch();
    if (!aborted) test_store();
    if (!aborted) test_fetch_store();
    if (!aborted) test_timer();
    bp_en = 1'b1;  // same tests under slave back-pressure
    if (!aborted) test_fetch();
    if (!aborted) test_store();
    $display("checks %0d, errors %0d, aborted %0d", checks, errors, aborted);
    if (errors == 0 && !aborted) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
bus_pkg.sv
soc_map_pkg.sv
clint_timer.sv
lane_align.sv
bus_arbiter.sv
cpu_bus_top.sv
tb_axi_mem.sv
tb_cpu_bus.sv

/* Makefile */
# Verilator build and run for the cpu bus testbench

TOP       ?= tb_cpu_bus
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
